// ==== frontEnd.f ====
design/frontPkg.sv
design/immGen.sv
design/ctrlDecode.sv
design/instrFetch.sv
design/regScoreboard.sv
design/decodeStage.sv
design/frontEnd.sv
verification/frontEnd_sva.sv
verification/frontEndTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = frontEndTb
FILELIST = frontEnd.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/frontEndTb.sv ====
`timescale 1ns/1ns

module frontEndTb;
    import frontPkg::*;

    localparam addrT base   = 64'h8000_0000;
    localparam addrT target = 64'h8000_0100;

    logic    clk = 1'b0;
    logic    rst;
    logic    jmp;
    addrT    jmpTarget;
    logic    wbCyc;
    logic    wbStb;
    logic    wbWe;
    logic [3:0] wbSel;
    addrT    wbAdr;
    instrT   wbDatI = '0;
    logic    wbAck = 1'b0;
    logic    issueValid;
    logic    issueReady;
    addrT    issuePc;
    immT     issueImm;
    regIdxT  issueRd;
    aluCtrlT issueAluCtrl;
    logic    issueAluASrc;
    logic [1:0] issueAluBSrc;
    branchT  issueBranch;
    logic    issueMemRd;
    logic    issueMemWr;
    logic    issueRegWr;
    memOpT   issueMemOp;
    logic    issueCsr;
    csrAddrT issueCsrAddr;
    logic    issueEcall;
    logic    issueEbreak;
    logic    issueMret;
    logic    issueIllegal;
    logic    wbValid;
    regIdxT  wbIdx;

    instrT   mem [0:127];
    int      seed = 89;
    int      waitCnt = 0;
    int      ackDelay = 0;
    logic    slowAck;

    string   testName;
    int      errors = 0;
    int      testErrors = 0;
    int      checks = 0;
    int      tests = 0;

    addrT    gotPc;
    immT     gotImm;
    regIdxT  gotRd;
    branchT  gotBranch;
    logic    gotMemWr;
    memOpT   gotMemOp;
    logic    gotIllegal;
    logic    gotCsr;
    csrAddrT gotCsrAddr;
    logic [2:0] gotSys;   // ecall, ebreak, mret
    aluCtrlT gotAluCtrl;
    logic    gotASrc;
    logic [1:0] gotBSrc;
    logic    gotMemRd;
    logic    gotRegWr;

    frontEnd #(.resetVector(base)) uut (.*);

    always #5 clk = ~clk;

    // instruction encoders, straight from the ISA formats
    function automatic instrT iType(immT imm, regIdxT rs1, logic [2:0] f3, regIdxT rd,
                                    logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic instrT sType(immT imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic instrT bType(immT imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic instrT uType(logic [19:0] imm, regIdxT rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instrT jType(immT imm, regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic instrT rType(logic [6:0] f7, regIdxT rs2, regIdxT rs1, logic [2:0] f3,
                                    regIdxT rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // addi x0, x0 with a hash of the address as immediate
    function automatic instrT fillWord(addrT a);
        logic [31:0] fold;
        logic [11:0] h;
        fold = a[63:32] ^ a[31:0];
        h = fold[31:20] ^ fold[19:8] ^ {fold[7:0], 4'h0};
        return {h, 20'h00013};
    endfunction

    function automatic instrT memRead(addrT a);
        addrT off;
        off = a - base;
        if (off < 64'd512) return mem[off[8:2]];
        else return fillWord(a);
    endfunction

    task automatic noteFailure(string msg);
        errors++;
        testErrors++;
        $display("%s: %s", testName, msg);
    endtask

    task automatic checkVal(string what, logic [63:0] expected, logic [63:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            testErrors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
        end
    endtask

    // Wishbone slave with 0 to 3 cycles of ack latency
    always @(negedge clk) begin
        if (rst) begin
            wbAck   <= 1'b0;
            waitCnt <= 0;
        end else if (wbAck) begin
            wbAck    <= 1'b0;
            waitCnt  <= 0;
            ackDelay <= $unsigned($random(seed)) % 4;
        end else if (wbCyc && wbStb) begin
            if (waitCnt >= (slowAck ? 12 : ackDelay)) begin
                checkVal("wbWe", 64'(0), 64'(wbWe));
                checkVal("wbSel", 64'hf, 64'(wbSel));
                wbAck  <= 1'b1;
                wbDatI <= memRead(wbAdr);
            end else begin
                waitCnt <= waitCnt + 1;
            end
        end
    end

    task automatic checkPcRd(addrT expPc, regIdxT expRd);
        checkVal("pc", expPc, gotPc);
        checkVal("rd", 64'(expRd), 64'(gotRd));
    endtask

    task automatic checkImm(immT expImm);
        checkVal("imm", 64'(expImm), 64'(gotImm));
    endtask

    task automatic captureIssue();
        gotPc      = issuePc;
        gotImm     = issueImm;
        gotRd      = issueRd;
        gotBranch  = issueBranch;
        gotMemWr   = issueMemWr;
        gotMemOp   = issueMemOp;
        gotIllegal = issueIllegal;
        gotCsr     = issueCsr;
        gotCsrAddr = issueCsrAddr;
        gotSys     = {issueEcall, issueEbreak, issueMret};
        gotAluCtrl = issueAluCtrl;
        gotASrc    = issueAluASrc;
        gotBSrc    = issueAluBSrc;
        gotMemRd   = issueMemRd;
        gotRegWr   = issueRegWr;
    endtask

    // sampled on the falling edge, taken by the DUT on the next rising edge
    task automatic waitIssue();
        int   n;
        logic found;
        found = 1'b0;
        n = 0;
        while (!found && n < 200) begin
            @(negedge clk);
            n++;
            if (issueValid) begin
                found = 1'b1;
                captureIssue();
            end
        end
        checks++;
        assert (found) else noteFailure("timed out waiting for an issued instruction");
    endtask

    task automatic startTest(string name);
        int i;
        testName   = name;
        testErrors = 0;
        @(negedge clk);
        jmp        = 1'b0;
        wbValid    = 1'b0;
        issueReady = 1'b1;
        slowAck    = 1'b0;
        for (i = 0; i < 128; i++) mem[i] = fillWord(base + 64'(4 * i));
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic pulseJmp(addrT to);
        jmp       = 1'b1;
        jmpTarget = to;
        @(negedge clk);
        jmp = 1'b0;
    endtask

    task automatic endTest();
        tests++;
        $display("test %-12s finished with %0d errors", testName, testErrors);
    endtask

    task automatic seqFetchTest();
        immT     expImm [6];
        regIdxT  expRd [6];
        branchT  expBr [6];
        aluCtrlT expAlu [6];
        logic    expASrc [6];
        logic [1:0] expBSrc [6];
        logic    expRegWr [6];
        memOpT   expOp [6];
        int      i;
        startTest("seqFetch");
        mem[0] = uType(20'h12345, 5'd1, 7'h37);   // lui x1
        mem[1] = uType(20'hfffff, 5'd2, 7'h17);   // auipc x2
        mem[2] = iType(32'hffff_fffb, 5'd0, 3'b000, 5'd3, 7'h13);
        mem[3] = sType(32'hffff_ffe0, 5'd0, 5'd0, 3'b011);   // sd x0, -32(x0)
        mem[4] = bType(32'h0000_07e0, 5'd0, 5'd0, 3'b000);
        mem[5] = jType(32'hffff_f800, 5'd7);
        expImm = '{32'h1234_5000, 32'hffff_f000, 32'hffff_fffb,
                   32'hffff_ffe0, 32'h0000_07e0, 32'hffff_f800};
        expRd  = '{5'd1, 5'd2, 5'd3, 5'd0, 5'd0, 5'd7};
        expBr  = '{3'b000, 3'b000, 3'b000, 3'b000, 3'b100, 3'b001};
        expAlu = '{6'h0f, 6'h00, 6'h00, 6'h00, 6'h02, 6'h00};
        expASrc  = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};   // pc as operand a
        expBSrc  = '{2'd2, 2'd2, 2'd2, 2'd2, 2'd0, 2'd1};
        expRegWr = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
        expOp    = '{3'b101, 3'b111, 3'b000, 3'b011, 3'b000, 3'b111};   // bits 14:12
        applyReset();
        for (i = 0; i < 6; i++) begin
            waitIssue();
            checkPcRd(base + 64'(4 * i), expRd[i]);
            checkImm(expImm[i]);
            checkVal("branch", 64'(expBr[i]), 64'(gotBranch));
            checkVal("memWr", 64'(i == 3), 64'(gotMemWr));
            checkVal("memOp", 64'(expOp[i]), 64'(gotMemOp));
            checkVal("illegal", 64'(0), 64'(gotIllegal));
            checkVal("aluCtrl", 64'(expAlu[i]), 64'(gotAluCtrl));
            checkVal("aluASrc", 64'(expASrc[i]), 64'(gotASrc));
            checkVal("aluBSrc", 64'(expBSrc[i]), 64'(gotBSrc));
            checkVal("memRd", 64'(0), 64'(gotMemRd));
            checkVal("regWr", 64'(expRegWr[i]), 64'(gotRegWr));
        end
        endTest();
    endtask

    task automatic illegalTest();
        int i;
        startTest("illegal");
        mem[0] = 32'h0000_007f;   // opcode 11111
        mem[1] = iType(32'd1, 5'd0, 3'b000, 5'd1, 7'h10);   // addi with low bits 00
        mem[2] = sType(32'd0, 5'd0, 5'd0, 3'b100);
        mem[3] = iType(32'd2, 5'd0, 3'b000, 5'd0, 7'h73);
        applyReset();
        for (i = 0; i < 4; i++) begin
            waitIssue();
            checkVal("pc", base + 64'(4 * i), gotPc);
            checkVal("illegal", 64'(1), 64'(gotIllegal));
        end
        endTest();
    endtask

    task automatic systemTest();
        logic [2:0] expSys [4];
        int         i;
        startTest("system");
        mem[0] = 32'h0000_0073;   // ecall
        mem[1] = 32'h0010_0073;   // ebreak
        mem[2] = 32'h3020_0073;   // mret
        mem[3] = iType(32'h340, 5'd0, 3'b001, 5'd0, 7'h73);   // csrrw x0, mscratch, x0
        expSys = '{3'b100, 3'b010, 3'b001, 3'b000};
        applyReset();
        for (i = 0; i < 4; i++) begin
            waitIssue();
            checkVal("pc", base + 64'(4 * i), gotPc);
            checkVal("sysFlags", 64'(expSys[i]), 64'(gotSys));
            checkVal("illegal", 64'(0), 64'(gotIllegal));
        end
        checkVal("csr", 64'(1), 64'(gotCsr));
        checkVal("csrAddr", 64'h340, 64'(gotCsrAddr));
        endTest();
    endtask

    task automatic rawHoldTest();
        logic early;
        startTest("rawHold");
        mem[0] = iType(32'd1, 5'd0, 3'b000, 5'd5, 7'h13);   // addi x5, x0, 1
        mem[1] = rType(7'h00, 5'd1, 5'd5, 3'b000, 5'd6, 7'h33);   // add x6, x5, x1
        mem[2] = uType(20'h00030, 5'd7, 7'h37);   // lui x7, rs1 field reads 6
        applyReset();
        waitIssue();
        checkPcRd(base, 5'd5);
        early = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (issueValid) early = 1'b1;
        end
        checkVal("issued before writeback", 64'(0), 64'(early));
        wbValid = 1'b1;
        wbIdx   = 5'd5;
        @(negedge clk);
        checkVal("release after writeback", 64'(1), 64'(issueValid));
        captureIssue();
        wbValid = 1'b0;
        checkPcRd(base + 64'd4, 5'd6);
        waitIssue();   // x6 still pending here
        checkPcRd(base + 64'd8, 5'd7);
        checkImm(32'h0003_0000);
        endTest();
    endtask

    task automatic backPressureTest();
        logic moved;
        int   hold;
        int   i;
        startTest("backPressure");
        for (i = 0; i < 6; i++) mem[i] = iType(immT'(i * 3 + 1), 5'd0, 3'b000,
                                               regIdxT'(i + 1), 7'h13);
        applyReset();
        issueReady = 1'b0;
        for (i = 0; i < 6; i++) begin
            waitIssue();
            checkPcRd(base + 64'(4 * i), regIdxT'(i + 1));
            checkImm(immT'(i * 3 + 1));
            hold  = 1 + $unsigned($random(seed)) % 5;
            moved = 1'b0;
            repeat (hold) begin
                @(negedge clk);
                if (!issueValid || issuePc != gotPc || issueImm != gotImm || issueRd != gotRd)
                    moved = 1'b1;
            end
            checkVal("stalled fields moved", 64'(0), 64'(moved));
            issueReady = 1'b1;
            @(negedge clk);
            issueReady = 1'b0;
        end
        endTest();
    endtask

    task automatic redirectTest();
        logic early;
        int   n;
        startTest("redirect");
        mem[0]  = iType(32'd1, 5'd0, 3'b000, 5'd5, 7'h13);
        mem[1]  = rType(7'h00, 5'd0, 5'd5, 3'b000, 5'd6, 7'h33);   // waits on x5
        mem[64] = iType(32'h55, 5'd0, 3'b000, 5'd9, 7'h13);   // first word at target
        slowAck = 1'b1;
        applyReset();
        n = 0;
        while (!wbCyc && n < 50) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (wbCyc) else noteFailure("no bus request after reset");
        repeat (3) @(negedge clk);
        pulseJmp(target);   // lands inside the slow bus cycle
        slowAck = 1'b0;
        waitIssue();
        checkPcRd(target, 5'd9);
        checkImm(32'h55);

        applyReset();
        waitIssue();
        checkPcRd(base, 5'd5);
        early = 1'b0;
        repeat (5) begin
            @(negedge clk);
            if (issueValid) early = 1'b1;
        end
        checkVal("held add issued", 64'(0), 64'(early));
        pulseJmp(target);
        waitIssue();
        checkPcRd(target, 5'd9);
        endTest();
    endtask

    initial begin
        rst        = 1'b1;
        jmp        = 1'b0;
        jmpTarget  = '0;
        issueReady = 1'b1;
        wbValid    = 1'b0;
        wbIdx      = '0;
        slowAck    = 1'b0;
        seqFetchTest();
        illegalTest();
        systemTest();
        rawHoldTest();
        backPressureTest();
        redirectTest();
        errors = errors + uut.uSva.failCount;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verification/frontEnd_sva.sv ====
`timescale 1ns/1ns

module frontEndSva (
    input logic              clk,
    input logic              rst,
    input logic              jmp,
    input logic              wbCyc,
    input logic              wbStb,
    input logic              wbAck,
    input frontPkg::addrT    wbAdr,
    input logic              issueValid,
    input logic              issueReady,
    input frontPkg::addrT    issuePc,
    input frontPkg::immT     issueImm,
    input frontPkg::regIdxT  issueRd,
    input frontPkg::aluCtrlT issueAluCtrl,
    input logic              issueAluASrc,
    input logic [1:0]        issueAluBSrc,
    input frontPkg::branchT  issueBranch,
    input logic              issueMemRd,
    input logic              issueMemWr,
    input logic              issueRegWr,
    input frontPkg::memOpT   issueMemOp,
    input logic              issueCsr,
    input logic              issueEcall,
    input logic              issueEbreak,
    input logic              issueMret,
    input logic              issueIllegal,
    input frontPkg::csrAddrT issueCsrAddr
);
    int failCount = 0;

    stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
        else begin
            failCount++;
            $error("wbStb high without wbCyc");
        end

    adrHeld: assert property (@(posedge clk) disable iff (rst)
        (wbStb && !wbAck) |=> $stable(wbAdr))
        else begin
            failCount++;
            $error("wbAdr changed inside an open bus cycle");
        end

    // a redirect may drop a stalled instruction
    issueHeld: assert property (@(posedge clk) disable iff (rst)
        (issueValid && !issueReady) |=> jmp || (issueValid
            && $stable({issuePc, issueImm, issueRd, issueAluCtrl, issueAluASrc, issueAluBSrc,
                        issueBranch, issueMemRd, issueMemWr, issueRegWr, issueMemOp,
                        issueCsr, issueCsrAddr, issueEcall, issueEbreak, issueMret,
                        issueIllegal})))
        else begin
            failCount++;
            $error("issue outputs changed while stalled");
        end

endmodule

bind frontEnd frontEndSva uSva (.*);

// ==== design/frontEnd.sv ====
`timescale 1ns/1ns

module frontEnd #(
    parameter frontPkg::addrT resetVector = 64'h8000_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              jmp,
    input  frontPkg::addrT    jmpTarget,
    output logic              wbCyc,
    output logic              wbStb,
    output logic              wbWe,
    output logic [3:0]        wbSel,
    output frontPkg::addrT    wbAdr,
    input  frontPkg::instrT   wbDatI,
    input  logic              wbAck,
    output logic              issueValid,
    input  logic              issueReady,
    output frontPkg::addrT    issuePc,
    output frontPkg::immT     issueImm,
    output frontPkg::regIdxT  issueRd,
    output frontPkg::aluCtrlT issueAluCtrl,
    output logic              issueAluASrc,
    output logic [1:0]        issueAluBSrc,
    output frontPkg::branchT  issueBranch,
    output logic              issueMemRd,
    output logic              issueMemWr,
    output logic              issueRegWr,
    output frontPkg::memOpT   issueMemOp,
    output logic              issueCsr,
    output frontPkg::csrAddrT issueCsrAddr,
    output logic              issueEcall,
    output logic              issueEbreak,
    output logic              issueMret,
    output logic              issueIllegal,
    input  logic              wbValid,
    input  frontPkg::regIdxT  wbIdx
);
    import frontPkg::*;

    logic   fetchValid;
    logic   fetchReady;
    instrT  fetchInstr;
    addrT   fetchPc;
    regIdxT rs1Idx;
    regIdxT rs2Idx;
    logic   rs1Ready;
    logic   rs2Ready;
    logic   setValid;
    regIdxT setIdx;

    instrFetch #(
        .resetVector (resetVector)
    ) uFetch (
        .clk        (clk),
        .rst        (rst),
        .jmp        (jmp),
        .jmpTarget  (jmpTarget),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbSel      (wbSel),
        .wbAdr      (wbAdr),
        .wbDatI     (wbDatI),
        .wbAck      (wbAck),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .fetchInstr (fetchInstr),
        .fetchPc    (fetchPc)
    );

    decodeStage uDecode (
        .clk          (clk),
        .rst          (rst),
        .jmp          (jmp),
        .fetchValid   (fetchValid),
        .fetchReady   (fetchReady),
        .fetchInstr   (fetchInstr),
        .fetchPc      (fetchPc),
        .rs1Idx       (rs1Idx),
        .rs2Idx       (rs2Idx),
        .rs1Ready     (rs1Ready),
        .rs2Ready     (rs2Ready),
        .setValid     (setValid),
        .setIdx       (setIdx),
        .issueValid   (issueValid),
        .issueReady   (issueReady),
        .issuePc      (issuePc),
        .issueImm     (issueImm),
        .issueRd      (issueRd),
        .issueAluCtrl (issueAluCtrl),
        .issueAluASrc (issueAluASrc),
        .issueAluBSrc (issueAluBSrc),
        .issueBranch  (issueBranch),
        .issueMemRd   (issueMemRd),
        .issueMemWr   (issueMemWr),
        .issueRegWr   (issueRegWr),
        .issueMemOp   (issueMemOp),
        .issueCsr     (issueCsr),
        .issueCsrAddr (issueCsrAddr),
        .issueEcall   (issueEcall),
        .issueEbreak  (issueEbreak),
        .issueMret    (issueMret),
        .issueIllegal (issueIllegal)
    );

    regScoreboard uScoreboard (
        .clk      (clk),
        .rst      (rst),
        .setValid (setValid),
        .setIdx   (setIdx),
        .wbValid  (wbValid),
        .wbIdx    (wbIdx),
        .rs1Idx   (rs1Idx),
        .rs2Idx   (rs2Idx),
        .rs1Ready (rs1Ready),
        .rs2Ready (rs2Ready)
    );

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              jmp,
    input  logic              fetchValid,
    output logic              fetchReady,
    input  frontPkg::instrT   fetchInstr,
    input  frontPkg::addrT    fetchPc,
    output frontPkg::regIdxT  rs1Idx,
    output frontPkg::regIdxT  rs2Idx,
    input  logic              rs1Ready,
    input  logic              rs2Ready,
    output logic              setValid,
    output frontPkg::regIdxT  setIdx,
    output logic              issueValid,
    input  logic              issueReady,
    output frontPkg::addrT    issuePc,
    output frontPkg::immT     issueImm,
    output frontPkg::regIdxT  issueRd,
    output frontPkg::aluCtrlT issueAluCtrl,
    output logic              issueAluASrc,
    output logic [1:0]        issueAluBSrc,
    output frontPkg::branchT  issueBranch,
    output logic              issueMemRd,
    output logic              issueMemWr,
    output logic              issueRegWr,
    output frontPkg::memOpT   issueMemOp,
    output logic              issueCsr,
    output frontPkg::csrAddrT issueCsrAddr,
    output logic              issueEcall,
    output logic              issueEbreak,
    output logic              issueMret,
    output logic              issueIllegal
);
    import frontPkg::*;

    logic   validQ;
    instrT  instrQ;
    addrT   pcQ;
    immFmtT immFmt;
    logic   rType;
    logic   needRs1;
    logic   needRs2;
    logic   hazard;
    logic   issueFire;

    assign issueFire  = issueValid && issueReady;
    assign fetchReady = (!validQ || issueFire) && !jmp;

    always_ff @(posedge clk) begin
        if (rst || jmp) validQ <= 1'b0;   // redirect flushes decode
        else if (fetchReady) validQ <= fetchValid;
    end

    always_ff @(posedge clk) begin
        if (fetchReady && fetchValid) begin
            instrQ <= fetchInstr;
            pcQ    <= fetchPc;
        end
    end

    ctrlDecode uCtrl (
        .instr   (instrQ),
        .immFmt  (immFmt),
        .aluCtrl (issueAluCtrl),
        .aluASrc (issueAluASrc),
        .aluBSrc (issueAluBSrc),
        .branch  (issueBranch),
        .memRd   (issueMemRd),
        .memWr   (issueMemWr),
        .regWr   (issueRegWr),
        .csr     (issueCsr),
        .illegal (issueIllegal),
        .memOp   (issueMemOp)
    );

    immGen uImm (
        .instr  (instrQ),
        .immFmt (immFmt),
        .imm    (issueImm)
    );

    // R-type shares the S code, so pick it out by opcode
    assign rType   = (instrQ[6:2] == opReg) || (instrQ[6:2] == opReg32);
    assign needRs1 = (immFmt != immU) && (immFmt != immJ)
                  && !(issueCsr && instrQ[14]);   // csr immediate forms have no rs1
    assign needRs2 = (immFmt == immS) || (immFmt == immB) || rType;
    assign hazard  = validQ && !issueIllegal
                  && ((needRs1 && !rs1Ready) || (needRs2 && !rs2Ready));

    assign issueValid   = validQ && !hazard && !jmp;
    assign rs1Idx       = instrQ[19:15];
    assign rs2Idx       = instrQ[24:20];
    assign issueRd      = instrQ[11:7];
    assign issuePc      = pcQ;
    assign issueCsrAddr = instrQ[31:20];
    assign issueEcall   = (instrQ == instrEcall);
    assign issueEbreak  = (instrQ == instrEbreak);
    assign issueMret    = (instrQ == instrMret);

    assign setValid = issueFire && issueRegWr && (issueRd != 5'd0);
    assign setIdx   = issueRd;

endmodule

// ==== design/regScoreboard.sv ====
`timescale 1ns/1ns

module regScoreboard (
    input  logic             clk,
    input  logic             rst,
    input  logic             setValid,
    input  frontPkg::regIdxT setIdx,
    input  logic             wbValid,
    input  frontPkg::regIdxT wbIdx,
    input  frontPkg::regIdxT rs1Idx,
    input  frontPkg::regIdxT rs2Idx,
    output logic             rs1Ready,
    output logic             rs2Ready
);
    import frontPkg::*;

    logic [31:0] pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wbValid) pending[wbIdx] <= 1'b0;
            if (setValid) pending[setIdx] <= 1'b1;   // set after clear so it wins
            pending[0] <= 1'b0;   // x0 is never pending
        end
    end

    assign rs1Ready = !pending[rs1Idx];
    assign rs2Ready = !pending[rs2Idx];

endmodule

// ==== design/instrFetch.sv ====
`timescale 1ns/1ns

module instrFetch #(
    parameter frontPkg::addrT resetVector = 64'h8000_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            jmp,
    input  frontPkg::addrT  jmpTarget,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output logic [3:0]      wbSel,
    output frontPkg::addrT  wbAdr,
    input  frontPkg::instrT wbDatI,
    input  logic            wbAck,
    output logic            fetchValid,
    input  logic            fetchReady,
    output frontPkg::instrT fetchInstr,
    output frontPkg::addrT  fetchPc
);
    import frontPkg::*;

    fetchStateT state;
    addrT       pc;
    addrT       pcNext;
    logic       discard;   // redirect seen while the bus cycle was open
    logic       take;

    assign take    = fetchValid && fetchReady;
    assign pcNext  = jmp ? jmpTarget : (take ? pc + 64'd4 : pc);

    assign wbCyc      = (state == busReq);
    assign wbStb      = (state == busReq);
    assign wbWe       = 1'b0;
    assign wbSel      = 4'hf;
    assign fetchValid = (state == hold);
    assign fetchPc    = pc;   // pc only moves once the buffer is taken

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            pc      <= resetVector;
            discard <= 1'b0;
        end else begin
            pc <= pcNext;
            case (state)
                idle: begin
                    if (!jmp) state <= busReq;   // start once pc has settled
                end
                busReq: begin
                    if (wbAck) begin
                        discard <= 1'b0;
                        state   <= (discard || jmp) ? idle : hold;
                    end else if (jmp) begin
                        discard <= 1'b1;
                    end
                end
                hold: begin
                    if (jmp) state <= idle;
                    else if (fetchReady) state <= busReq;
                end
                default: state <= idle;
            endcase
        end
    end

    // address is frozen while the cycle is open
    always_ff @(posedge clk) begin
        if (state != busReq) wbAdr <= pcNext;
        if (state == busReq && wbAck) fetchInstr <= wbDatI;
    end

endmodule

// ==== design/ctrlDecode.sv ====
`timescale 1ns/1ns

module ctrlDecode (
    input  frontPkg::instrT   instr,
    output frontPkg::immFmtT  immFmt,
    output frontPkg::aluCtrlT aluCtrl,
    output logic              aluASrc,
    output logic [1:0]        aluBSrc,
    output frontPkg::branchT  branch,
    output logic              memRd,
    output logic              memWr,
    output logic              regWr,
    output logic              csr,
    output logic              illegal,
    output frontPkg::memOpT   memOp
);
    import frontPkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [3:0] aluOp;
    logic       err;
    logic       sysOk;
    logic       reg32Ok;
    logic       mulDiv;
    logic       wordOp;

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign sysOk = (instr == instrEcall) || (instr == instrEbreak) || (instr == instrMret);

    // OP-32 has no logic ops and only a subset of M
    assign reg32Ok = (funct7 == 7'h00 && (funct3 == 3'b000 || funct3 == 3'b001
                                          || funct3 == 3'b101))
                  || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))
                  || (funct7 == 7'h01 && (funct3 == 3'b000 || funct3[2]));

    always_comb begin
        immFmt  = immI;
        aluBSrc = 2'd0;   // 0 rs2, 1 four, 2 imm, 3 csr
        aluOp   = 4'b0000;
        branch  = 3'b000;
        err     = 1'b0;
        case (opcode)
            opLui: begin
                immFmt  = immU;
                aluBSrc = 2'd2;
                aluOp   = 4'b1111;
            end
            opAuipc: begin
                immFmt  = immU;
                aluBSrc = 2'd2;
            end
            opJal: begin
                immFmt  = immJ;
                aluBSrc = 2'd1;
                branch  = 3'b001;
            end
            opJalr: begin
                aluBSrc = 2'd1;
                branch  = 3'b010;
                err     = (funct3 != 3'b000);
            end
            opBranch: begin
                immFmt = immB;
                aluOp  = funct3[1] ? 4'b0011 : 4'b0010;   // unsigned compare for bltu/bgeu
                branch = {1'b1, funct3[2], funct3[0]};
                err    = (funct3[2:1] == 2'b01);
            end
            opLoad: begin
                aluBSrc = 2'd2;
                err     = (funct3 == 3'b111);
            end
            opStore: begin
                immFmt  = immS;
                aluBSrc = 2'd2;
                err     = funct3[2];
            end
            opImm: begin
                aluBSrc = 2'd2;
                aluOp   = {funct7[5] && funct3 == 3'b101, funct3};
                err     = (funct3 == 3'b001 && funct7[6:1] != 6'b000000)
                       || (funct3 == 3'b101 && funct7[6:1] != 6'b000000
                           && funct7[6:1] != 6'b010000);
            end
            opImm32: begin
                aluBSrc = 2'd2;
                aluOp   = {funct7[5] && funct3 == 3'b101, funct3};
                err     = (funct3 != 3'b000)
                       && (funct3 != 3'b001 || funct7 != 7'h00)
                       && (funct3 != 3'b101 || (funct7 != 7'h00 && funct7 != 7'h20));
            end
            opReg: begin
                immFmt = immS;
                aluOp  = {funct7[5], funct3};
                err    = !(funct7 == 7'h00 || funct7 == 7'h01
                           || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            opReg32: begin
                immFmt = immS;
                aluOp  = {funct7[5], funct3};
                err    = !reg32Ok;
            end
            opSystem: begin
                aluBSrc = 2'd3;
                aluOp   = 4'b1111;
                err     = (funct3 == 3'b100) || (funct3 == 3'b000 && !sysOk);
            end
            default: err = 1'b1;
        endcase
    end

    assign mulDiv  = (opcode == opReg || opcode == opReg32) && funct7 == 7'h01;
    assign wordOp  = (opcode == opReg32 || opcode == opImm32);
    assign aluCtrl = {mulDiv, wordOp, aluOp};
    assign aluASrc = (opcode == opAuipc) || (opcode == opJal) || (opcode == opJalr);
    assign illegal = err || (instr[1:0] != 2'b11);
    assign memRd   = (opcode == opLoad);
    assign memWr   = (opcode == opStore);
    assign csr     = (opcode == opSystem);
    assign memOp   = funct3;
    assign regWr   = !(opcode == opBranch || opcode == opStore) && !illegal;   // no rd on junk

endmodule

// ==== design/immGen.sv ====
`timescale 1ns/1ns

module immGen (
    input  frontPkg::instrT  instr,
    input  frontPkg::immFmtT immFmt,
    output frontPkg::immT    imm
);
    import frontPkg::*;

    logic [2:0] fmt;

    assign fmt = immFmt;   // bit view, U=1xx, J/U=x01, S/B=x1x

    assign imm[31]    = instr[31];
    assign imm[30:20] = fmt[2] ? instr[30:20] : {11{instr[31]}};
    assign imm[19:12] = (~fmt[1] & fmt[0]) ? instr[19:12] : {8{instr[31]}};
    assign imm[11]    = fmt[2]  ? 1'b0 :
                        ~fmt[0] ? instr[31] :   // I and S
                        fmt[1]  ? instr[7] : instr[20];   // B or J
    assign imm[10:5]  = fmt[2] ? 6'b0 : instr[30:25];
    assign imm[4:1]   = fmt[2] ? 4'b0 :
                        fmt[1] ? instr[11:8] : instr[24:21];
    assign imm[0]     = fmt[0] ? 1'b0 :
                        fmt[1] ? instr[7] : instr[20];

endmodule

// ==== design/frontPkg.sv ====
package frontPkg;

    typedef logic [31:0] instrT;
    typedef logic [63:0] addrT;
    typedef logic [31:0] immT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  aluCtrlT;   // [5] mul/div, [4] word op, [3:0] operation
    typedef logic [2:0]  branchT;
    typedef logic [2:0]  memOpT;     // size and sign, same as funct3
    typedef logic [11:0] csrAddrT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immJ = 3'b001,
        immS = 3'b010,   // R-type opcodes report this one too
        immB = 3'b011,
        immU = 3'b101
    } immFmtT;

    typedef enum logic [1:0] {
        idle,
        busReq,
        hold
    } fetchStateT;

    // major opcodes, instr[6:2]
    localparam logic [4:0] opLui    = 5'b01101;
    localparam logic [4:0] opAuipc  = 5'b00101;
    localparam logic [4:0] opJal    = 5'b11011;
    localparam logic [4:0] opJalr   = 5'b11001;
    localparam logic [4:0] opBranch = 5'b11000;
    localparam logic [4:0] opLoad   = 5'b00000;
    localparam logic [4:0] opStore  = 5'b01000;
    localparam logic [4:0] opImm    = 5'b00100;
    localparam logic [4:0] opImm32  = 5'b00110;
    localparam logic [4:0] opReg    = 5'b01100;
    localparam logic [4:0] opReg32  = 5'b01110;
    localparam logic [4:0] opSystem = 5'b11100;

    localparam instrT instrEcall  = 32'h0000_0073;
    localparam instrT instrEbreak = 32'h0010_0073;
    localparam instrT instrMret   = 32'h3020_0073;

endpackage
